/* include/mac_tx_defines.svh */
// frame layout, widths and crc constants for the rmii mac transmitter
// include in any module that needs a length, a constant byte or a width
// payload length may be changed here, anything from 1 to 256 bytes

`ifndef MAC_TX_DEFINES_SVH
`define MAC_TX_DEFINES_SVH

// field lengths in bytes
`define MAC_TX_PREAMBLE_LEN   7
`define MAC_TX_HEADER_LEN     14       // dst + src + type
`define MAC_TX_PAYLOAD_LEN    136
`define MAC_TX_FCS_LEN        4

// constant bytes on the wire
`define MAC_TX_PREAMBLE_BYTE  8'h55
`define MAC_TX_SFD_BYTE       8'hD5

// widths
`define MAC_TX_RAM_AW         8        // payload ram address bits
`define MAC_TX_DIBITS         4        // rmii dibits per byte

// ieee 802.3 crc-32, reflected form
`define MAC_TX_CRC_INIT       32'hFFFF_FFFF
`define MAC_TX_CRC_POLY       32'hEDB8_8320

`endif

/* source/mac_tx_pkg.sv */
// shared types for the rmii mac transmitter
// sequencer states, beat field tags and the structs passed between stages
// modules take these with a wildcard import in the module header

package mac_tx_pkg;

    // frame sequencer states
    typedef enum logic [2:0]
    {
        ST_IDLE,
        ST_PREAMBLE,
        ST_SFD,
        ST_HEADER,
        ST_PAYLOAD,
        ST_FCS,
        ST_GAP          // single cycle after last fcs byte
    } tx_state_e;

    // which frame part a beat carries, none must stay zero
    typedef enum logic [2:0]
    {
        FLD_NONE = 3'd0,
        FLD_PREAMBLE,
        FLD_SFD,
        FLD_HEADER,
        FLD_PAYLOAD,
        FLD_FCS
    } tx_field_e;

    // ethernet header, each field goes out low byte first
    typedef struct packed
    {
        logic [47:0] destin_addr;
        logic [47:0] source_addr;
        logic [15:0] type_code;
    } mac_frame_hdr_t;

    // one byte slot travelling down the pipeline
    typedef struct packed
    {
        tx_field_e   field;
        logic [7:0]  index;    // byte position inside its field
        logic [7:0]  data;
    } tx_beat_t;

endpackage

/* source/mac_tx_sequencer.sv */
// frame sequencer, first stage of the transmit pipeline
// runs the dibit phase, walks the frame fields and issues one beat per byte
// time; payload bytes are requested from ram one cycle ahead of their beat
`timescale 1ns/10ps
`include "mac_tx_defines.svh"

module mac_tx_sequencer
    import mac_tx_pkg::*;
(
    input  logic                      i_sclk50,
    input  logic                      i_rst_n,
    input  logic                      i_start,      // single cycle pulse
    output tx_beat_t                  o_beat,
    output logic                      o_beat_stb,
    output logic                      o_ram_rden,
    output logic [`MAC_TX_RAM_AW-1:0] o_ram_raddr
);

    localparam logic [7:0] PRE_LAST = 8'(`MAC_TX_PREAMBLE_LEN - 1);
    localparam logic [7:0] HDR_LAST = 8'(`MAC_TX_HEADER_LEN - 1);
    localparam logic [7:0] PLD_LAST = 8'(`MAC_TX_PAYLOAD_LEN - 1);
    localparam logic [7:0] FCS_LAST = 8'(`MAC_TX_FCS_LEN - 1);

    logic [1:0]  phase;         // free running, 3 = byte boundary
    logic        start_q;
    tx_state_e   state;
    tx_state_e   nxt_state;
    logic [7:0]  byte_cnt;      // index of the byte now in its slot
    logic [7:0]  nxt_idx;
    tx_field_e   nxt_field;
    logic        payload_next;  // next beat needs ram data

    ////////////////////////////////////////
    // dibit phase and start latch
    ////////////////////////////////////////
    always_ff @(posedge i_sclk50 or negedge i_rst_n)
    begin
        if (!i_rst_n)
            phase <= 2'd0;
        else
            phase <= phase + 2'd1;
    end

    always_ff @(posedge i_sclk50 or negedge i_rst_n)
    begin
        if (!i_rst_n)
            start_q <= 1'b0;
        else if (i_start && state == ST_IDLE)
            start_q <= 1'b1;            // ignored mid frame
        else if (phase == 2'd3)
            start_q <= 1'b0;
    end

    ////////////////////////////////////////
    // frame fsm, advances on byte boundaries
    ////////////////////////////////////////
    always_comb
    begin
        nxt_state = state;
        if (state == ST_GAP)
        begin
            nxt_state = ST_IDLE;        // one cycle only
        end
        else if (phase == 2'd3)
        begin
            case (state)
                ST_IDLE:
                    if (start_q)
                        nxt_state = ST_PREAMBLE;
                ST_PREAMBLE:
                    if (byte_cnt == PRE_LAST)
                        nxt_state = ST_SFD;
                ST_SFD:
                    nxt_state = ST_HEADER;
                ST_HEADER:
                    if (byte_cnt == HDR_LAST)
                        nxt_state = ST_PAYLOAD;
                ST_PAYLOAD:
                    if (byte_cnt == PLD_LAST)
                        nxt_state = ST_FCS;
                ST_FCS:
                    if (byte_cnt == FCS_LAST)
                        nxt_state = ST_GAP;
                default:
                    nxt_state = ST_IDLE;
            endcase
        end
    end

    // index restarts with each new field
    assign nxt_idx = (nxt_state == state) ? byte_cnt + 8'd1 : 8'd0;

    always_comb
    begin
        case (nxt_state)
            ST_PREAMBLE: nxt_field = FLD_PREAMBLE;
            ST_SFD:      nxt_field = FLD_SFD;
            ST_HEADER:   nxt_field = FLD_HEADER;
            ST_PAYLOAD:  nxt_field = FLD_PAYLOAD;
            ST_FCS:      nxt_field = FLD_FCS;
            default:     nxt_field = FLD_NONE;
        endcase
    end

    always_ff @(posedge i_sclk50 or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            state    <= ST_IDLE;
            byte_cnt <= 8'd0;
        end
        else
        begin
            state <= nxt_state;
            if (o_beat_stb)
                byte_cnt <= nxt_idx;
        end
    end

    ////////////////////////////////////////
    // beat out, labelled with the slot it opens
    ////////////////////////////////////////
    assign o_beat_stb = (phase == 2'd3) && (nxt_field != FLD_NONE);

    always_comb
    begin
        o_beat       = '0;              // data filled downstream
        o_beat.field = nxt_field;
        o_beat.index = nxt_idx;
    end

    ////////////////////////////////////////
    // ram read, pulse lands on phase 2
    ////////////////////////////////////////
    assign payload_next = (state == ST_HEADER && byte_cnt == HDR_LAST) ||
                          (state == ST_PAYLOAD && byte_cnt != PLD_LAST);

    always_ff @(posedge i_sclk50 or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_ram_rden  <= 1'b0;
            o_ram_raddr <= '0;
        end
        else
        begin
            o_ram_rden <= (phase == 2'd1) && payload_next;
            if (phase == 2'd1 && payload_next)
                o_ram_raddr <= (state == ST_PAYLOAD) ?
                               `MAC_TX_RAM_AW'(byte_cnt + 8'd1) : '0;  // first byte at 0
        end
    end

endmodule

/* source/mac_tx_byte_mux.sv */
// byte mux, second pipeline stage
// fills the data byte of each beat from the constant bytes, the header
// fields or the ram word; adds one clock of latency
`timescale 1ns/10ps
`include "mac_tx_defines.svh"

module mac_tx_byte_mux
    import mac_tx_pkg::*;
(
    input  logic           i_sclk50,
    input  logic           i_rst_n,
    input  tx_beat_t       i_beat,
    input  logic           i_beat_stb,
    input  mac_frame_hdr_t i_frame_hdr,   // held for the whole frame
    input  logic [7:0]     i_ram_rdata,   // valid on the strobe edge
    output tx_beat_t       o_beat,
    output logic           o_beat_stb
);

    localparam int HDR_BITS = 8 * `MAC_TX_HEADER_LEN;

    logic [HDR_BITS-1:0] hdr_flat;  // byte 0 = dst low byte
    logic [7:0]          sel_byte;

    // low byte first within each field, dst then src then type
    assign hdr_flat = {i_frame_hdr.type_code,
                       i_frame_hdr.source_addr,
                       i_frame_hdr.destin_addr};

    ////////////////////////////////////////
    // data select
    ////////////////////////////////////////
    always_comb
    begin
        case (i_beat.field)
            FLD_PREAMBLE:
                sel_byte = `MAC_TX_PREAMBLE_BYTE;
            FLD_SFD:
                sel_byte = `MAC_TX_SFD_BYTE;
            FLD_HEADER:
                if (i_beat.index < 8'(`MAC_TX_HEADER_LEN))
                    sel_byte = hdr_flat[8*i_beat.index +: 8];
                else
                    sel_byte = 8'h00;
            FLD_PAYLOAD:
                sel_byte = i_ram_rdata;     // read issued one cycle earlier
            default:
                sel_byte = 8'h00;           // fcs slots filled later
        endcase
    end

    ////////////////////////////////////////
    // stage register
    ////////////////////////////////////////
    always_ff @(posedge i_sclk50 or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_beat     <= '0;
            o_beat_stb <= 1'b0;
        end
        else
        begin
            o_beat_stb <= i_beat_stb;
            if (i_beat_stb)
            begin
                o_beat.field <= i_beat.field;
                o_beat.index <= i_beat.index;
                o_beat.data  <= sel_byte;
            end
        end
    end

endmodule

/* source/mac_tx_fcs.sv */
// fcs stage, third pipeline stage
// runs crc-32 over header and payload bytes and writes the complemented
// result into the four fcs beats, low byte first; one clock of latency
`timescale 1ns/10ps
`include "mac_tx_defines.svh"

module mac_tx_fcs
    import mac_tx_pkg::*;
(
    input  logic     i_sclk50,
    input  logic     i_rst_n,
    input  tx_beat_t i_beat,
    input  logic     i_beat_stb,
    output tx_beat_t o_beat,
    output logic     o_beat_stb
);

    logic [31:0] crc_q;
    logic [31:0] crc_final;
    logic [7:0]  fcs_byte;

    // one byte through the reflected crc, lsb first
    function automatic logic [31:0] crc32_byte(input logic [31:0] crc_in,
                                               input logic [7:0]  din);
        logic [31:0] c;
        c = crc_in ^ {24'h0, din};
        for (int i = 0; i < 8; i++)
        begin
            if (c[0])
                c = (c >> 1) ^ `MAC_TX_CRC_POLY;
            else
                c = c >> 1;
        end
        return c;
    endfunction

    ////////////////////////////////////////
    // running crc
    ////////////////////////////////////////
    always_ff @(posedge i_sclk50 or negedge i_rst_n)
    begin
        if (!i_rst_n)
            crc_q <= `MAC_TX_CRC_INIT;
        else if (i_beat_stb)
        begin
            case (i_beat.field)
                FLD_SFD:
                    crc_q <= `MAC_TX_CRC_INIT;  // restart each frame
                FLD_HEADER,
                FLD_PAYLOAD:
                    crc_q <= crc32_byte(crc_q, i_beat.data);
                default:
                    crc_q <= crc_q;             // frozen over fcs
            endcase
        end
    end

    assign crc_final = ~crc_q;
    assign fcs_byte  = crc_final[8*i_beat.index[1:0] +: 8];

    ////////////////////////////////////////
    // stage register, fcs insert
    ////////////////////////////////////////
    always_ff @(posedge i_sclk50 or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_beat     <= '0;
            o_beat_stb <= 1'b0;
        end
        else
        begin
            o_beat_stb <= i_beat_stb;
            if (i_beat_stb)
            begin
                o_beat.field <= i_beat.field;
                o_beat.index <= i_beat.index;
                o_beat.data  <= (i_beat.field == FLD_FCS) ? fcs_byte : i_beat.data;
            end
        end
    end

endmodule

/* source/mac_tx_dibit_serializer.sv */
// dibit serializer, last pipeline stage
// shifts each beat byte onto the rmii pins as four dibits, lsb dibit first,
// first dibit one clock after the strobe; tx enable follows the dibits
`timescale 1ns/10ps
`include "mac_tx_defines.svh"

module mac_tx_dibit_serializer
    import mac_tx_pkg::*;
(
    input  logic       i_sclk50,
    input  logic       i_rst_n,
    input  tx_beat_t   i_beat,
    input  logic       i_beat_stb,
    output logic       o_tx_en,
    output logic [1:0] o_tx_data
);

    localparam logic [1:0] LAST_DIBIT = 2'(`MAC_TX_DIBITS - 1);

    logic [1:0] dibit_left;     // dibits still to go after the current one
    logic [5:0] shift_q;        // upper three dibits of the byte

    always_ff @(posedge i_sclk50 or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_tx_en    <= 1'b0;
            o_tx_data  <= 2'b00;
            dibit_left <= 2'd0;
        end
        else if (i_beat_stb)
        begin
            o_tx_en    <= (i_beat.field != FLD_NONE);
            o_tx_data  <= i_beat.data[1:0];
            dibit_left <= LAST_DIBIT;
        end
        else if (dibit_left != 2'd0)
        begin
            o_tx_data  <= shift_q[1:0];
            dibit_left <= dibit_left - 2'd1;
        end
        else
        begin
            o_tx_en   <= 1'b0;      // no new beat, frame over
            o_tx_data <= 2'b00;
        end
    end

    always_ff @(posedge i_sclk50)
    begin
        if (i_beat_stb)
            shift_q <= i_beat.data[7:2];
        else
            shift_q <= shift_q >> 2;
    end

endmodule

/* source/rmii_mac_tx.sv */
// rmii mac transmitter top level
// one fixed length ethernet frame per start pulse, dibits on i_sclk50
// pipeline is sequencer -> byte mux -> fcs -> dibit serializer,
// payload comes from an external ram with one cycle read latency
`timescale 1ns/10ps
`include "mac_tx_defines.svh"

module rmii_mac_tx
    import mac_tx_pkg::*;
(
    input  logic                      i_sclk50,
    input  logic                      i_rst_n,
    input  logic                      i_start,
    input  mac_frame_hdr_t            i_frame_hdr,
    input  logic [7:0]                i_ram_rdata,
    output logic                      o_ram_rden,
    output logic [`MAC_TX_RAM_AW-1:0] o_ram_raddr,
    output logic                      o_tx_en,
    output logic [1:0]                o_tx_data
);

    tx_beat_t seq_beat;     // sequencer -> mux
    logic     seq_beat_stb;
    tx_beat_t mux_beat;     // mux -> fcs
    logic     mux_beat_stb;
    tx_beat_t fcs_beat;     // fcs -> serializer
    logic     fcs_beat_stb;

    mac_tx_sequencer u_sequencer (
        .i_sclk50    (i_sclk50),
        .i_rst_n     (i_rst_n),
        .i_start     (i_start),
        .o_beat      (seq_beat),
        .o_beat_stb  (seq_beat_stb),
        .o_ram_rden  (o_ram_rden),
        .o_ram_raddr (o_ram_raddr)
    );

    mac_tx_byte_mux u_byte_mux (
        .i_sclk50    (i_sclk50),
        .i_rst_n     (i_rst_n),
        .i_beat      (seq_beat),
        .i_beat_stb  (seq_beat_stb),
        .i_frame_hdr (i_frame_hdr),
        .i_ram_rdata (i_ram_rdata),
        .o_beat      (mux_beat),
        .o_beat_stb  (mux_beat_stb)
    );

    mac_tx_fcs u_fcs (
        .i_sclk50    (i_sclk50),
        .i_rst_n     (i_rst_n),
        .i_beat      (mux_beat),
        .i_beat_stb  (mux_beat_stb),
        .o_beat      (fcs_beat),
        .o_beat_stb  (fcs_beat_stb)
    );

    mac_tx_dibit_serializer u_serializer (
        .i_sclk50    (i_sclk50),
        .i_rst_n     (i_rst_n),
        .i_beat      (fcs_beat),
        .i_beat_stb  (fcs_beat_stb),
        .o_tx_en     (o_tx_en),
        .o_tx_data   (o_tx_data)
    );

endmodule

/* testbench/tb_rmii_mac_tx.sv */
// testbench for the rmii mac transmitter
// models the payload ram, captures dibits into bytes while o_tx_en is high
// and checks preamble, header, payload, fcs and tx_en length per frame
// run through run_sim.sh which builds with the project file list
`timescale 1ns/10ps
`include "mac_tx_defines.svh"

module tb_rmii_mac_tx
    import mac_tx_pkg::*;
();

    localparam int HDR_LEN      = `MAC_TX_HEADER_LEN;
    localparam int PLD_LEN      = `MAC_TX_PAYLOAD_LEN;
    localparam int PLD_START    = 8 + HDR_LEN;               // after preamble and sfd
    localparam int FCS_START    = PLD_START + PLD_LEN;
    localparam int FRAME_BYTES  = FCS_START + `MAC_TX_FCS_LEN;
    localparam int RISE_TIMEOUT = 16;
    localparam int END_TIMEOUT  = FRAME_BYTES * 4 + 32;
    localparam int QUIET_CYCLES = 100;
    localparam int LATE_PULSE   = FRAME_BYTES * 4 - 3;       // last sequencer cycle in fcs

    logic                      i_sclk50 = 1'b0;
    logic                      i_rst_n;
    logic                      i_start;
    mac_frame_hdr_t            frame_hdr;
    logic [7:0]                i_ram_rdata = 8'h00;
    logic                      o_ram_rden;
    logic [`MAC_TX_RAM_AW-1:0] o_ram_raddr;
    logic                      o_tx_en;
    logic [1:0]                o_tx_data;

    logic [7:0] ram_mem [0:255];
    logic       rd_pending = 1'b0;
    logic [7:0] rd_addr    = 8'h00;
    int         rd_total   = 0;         // reads since time zero
    int         rd_base    = 0;         // rd_total at frame start
    int         ram_errors = 0;

    logic       en_prev     = 1'b0;
    logic [7:0] cap_byte    = 8'h00;
    int         dibit_n     = 0;
    int         en_run      = 0;
    int         run_len     = 0;        // tx_en high cycles of last frame
    int         frames_seen = 0;
    logic [7:0] cap_bytes [$];

    int errors       = 0;
    int tests_run    = 0;
    int tests_failed = 0;
    int latency;
    int err_start;
    int frames_before;
    int unsigned seed_dummy;

    always #2 i_sclk50 = ~i_sclk50;     // 4 ns period

    rmii_mac_tx uut (
        .i_sclk50    (i_sclk50),
        .i_rst_n     (i_rst_n),
        .i_start     (i_start),
        .i_frame_hdr (frame_hdr),
        .i_ram_rdata (i_ram_rdata),
        .o_ram_rden  (o_ram_rden),
        .o_ram_raddr (o_ram_raddr),
        .o_tx_en     (o_tx_en),
        .o_tx_data   (o_tx_data)
    );

    ////////////////////////////////////////
    // ram model and read address check
    ////////////////////////////////////////
    always @(negedge i_sclk50)
    begin
        if (rd_pending)
            i_ram_rdata <= ram_mem[rd_addr];  // valid for the edge after rden
        rd_pending <= o_ram_rden;
        rd_addr    <= o_ram_raddr;
        if (o_ram_rden)
        begin
            assert (o_ram_raddr == 8'(rd_total - rd_base))
            else
            begin
                $display("ERROR o_ram_raddr got 0x%02h expected 0x%02h",
                         o_ram_raddr, 8'(rd_total - rd_base));
                ram_errors++;
            end
            rd_total <= rd_total + 1;
        end
    end

    ////////////////////////////////////////
    // frame capture with lsb dibit first
    ////////////////////////////////////////
    always @(negedge i_sclk50)
    begin
        if (o_tx_en)
        begin
            if (!en_prev)
            begin
                cap_bytes.delete();     // new frame
                dibit_n = 0;
                en_run  = 0;
            end
            cap_byte = {o_tx_data, cap_byte[7:2]};
            dibit_n++;
            en_run++;
            if (dibit_n == 4)
            begin
                cap_bytes.push_back(cap_byte);
                dibit_n = 0;
            end
        end
        else if (en_prev)
        begin
            run_len = en_run;
            frames_seen++;
        end
        en_prev = o_tx_en;
    end

    function automatic int total_errors();
        return errors + ram_errors;
    endfunction

    task automatic check_hex(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("ERROR %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string msg);
        assert (cond)
        else
        begin
            $display("%s at %0t", msg, $time);
            errors++;
        end
    endtask

    task automatic fill_ram();
        int k;
        for (k = 0; k < 256; k++)
            ram_mem[k] = 8'($urandom);
    endtask

    task automatic randomize_header();
        frame_hdr.destin_addr = {16'($urandom), $urandom};
        frame_hdr.source_addr = {16'($urandom), $urandom};
        frame_hdr.type_code   = 16'($urandom);
    endtask

    // header byte i on the wire with each field low byte first
    function automatic logic [7:0] header_byte(input int i);
        if (i < 6)
            return frame_hdr.destin_addr[8*i +: 8];
        else if (i < 12)
            return frame_hdr.source_addr[8*(i-6) +: 8];
        else
            return frame_hdr.type_code[8*(i-12) +: 8];
    endfunction

    // reflected crc-32 bit by bit from all ones and complemented at the end
    function automatic logic [31:0] calc_fcs();
        logic [31:0] crc;
        logic [7:0]  b;
        logic        fb;
        int          k;
        int          j;
        crc = 32'hFFFF_FFFF;
        for (k = 0; k < HDR_LEN + PLD_LEN; k++)
        begin
            b = (k < HDR_LEN) ? header_byte(k) : ram_mem[k - HDR_LEN];
            for (j = 0; j < 8; j++)
            begin
                fb  = crc[0] ^ b[j];
                crc = {1'b0, crc[31:1]} ^ (fb ? 32'hEDB8_8320 : 32'h0);
            end
        end
        return ~crc;
    endfunction

    // start pulse and optional second pulse mid frame then wait for tx_en to fall
    task automatic send_frame(input int mid_pulse);
        int n;
        frames_before = frames_seen;
        rd_base = rd_total;
        @(negedge i_sclk50);
        i_start = 1'b1;
        latency = -1;
        n = 0;
        while (n < RISE_TIMEOUT && latency < 0)
        begin
            @(negedge i_sclk50);
            i_start = 1'b0;
            n++;
            if (o_tx_en)
                latency = n;
        end
        if (latency < 0)
        begin
            check_true(1'b0, "timeout, o_tx_en never rose after start");
            return;
        end
        n = 0;
        while (frames_seen == frames_before && n < END_TIMEOUT)
        begin
            @(negedge i_sclk50);
            n++;
            i_start = (mid_pulse > 0 && n == mid_pulse);
        end
        i_start = 1'b0;
        check_true(frames_seen != frames_before, "timeout, frame did not end");
    endtask

    task automatic check_layout();
        int k;
        check_true(latency >= 4 && latency <= 8,
                   $sformatf("start to first dibit took %0d cycles", latency));
        check_hex("o_tx_en high cycles", 32'(run_len), 32'(FRAME_BYTES * 4));
        check_hex("captured byte count", 32'(cap_bytes.size()), 32'(FRAME_BYTES));
        if (cap_bytes.size() != FRAME_BYTES)
            return;
        for (k = 0; k < 7; k++)
            check_hex($sformatf("o_tx_data byte %0d", k), 32'(cap_bytes[k]), 32'h55);
        check_hex("o_tx_data byte 7", 32'(cap_bytes[7]), 32'hD5);   // sfd
        for (k = 0; k < HDR_LEN; k++)
            check_hex($sformatf("o_tx_data byte %0d", 8 + k),
                      32'(cap_bytes[8 + k]), 32'(header_byte(k)));
    endtask

    task automatic check_payload();
        int k;
        check_hex("o_ram_rden count", 32'(rd_total - rd_base), 32'(PLD_LEN));
        if (cap_bytes.size() != FRAME_BYTES)
            return;
        for (k = 0; k < PLD_LEN; k++)
            check_hex($sformatf("o_tx_data byte %0d", PLD_START + k),
                      32'(cap_bytes[PLD_START + k]), 32'(ram_mem[k]));
    endtask

    task automatic check_fcs();
        logic [31:0] fcs;
        int          k;
        fcs = calc_fcs();
        if (cap_bytes.size() != FRAME_BYTES)
            return;
        for (k = 0; k < 4; k++)
            check_hex($sformatf("o_tx_data fcs byte %0d", k),
                      32'(cap_bytes[FCS_START + k]), 32'(fcs[8*k +: 8]));
    endtask

    task automatic end_test(input string name, input int err_before);
        tests_run++;
        if (total_errors() == err_before)
            $display("test %0d %s: ok", tests_run, name);
        else
        begin
            tests_failed++;
            $display("test %0d %s: failed, %0d errors", tests_run, name,
                     total_errors() - err_before);
        end
    endtask

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////
    initial
    begin
        seed_dummy = $urandom(56110);
        i_rst_n    = 1'b0;
        i_start    = 1'b0;
        frame_hdr  = '0;
        fill_ram();
        randomize_header();
        repeat (4) @(posedge i_sclk50);
        @(negedge i_sclk50);
        i_rst_n = 1'b1;

        err_start = total_errors();             // idle outputs
        repeat (20)
        begin
            @(negedge i_sclk50);
            check_hex("o_tx_en", 32'(o_tx_en), 32'h0);
            check_hex("o_ram_rden", 32'(o_ram_rden), 32'h0);
            check_hex("o_tx_data", 32'(o_tx_data), 32'h0);
        end
        end_test("idle after reset", err_start);

        err_start = total_errors();
        send_frame(0);
        check_layout();
        end_test("frame layout and tx_en length", err_start);
        err_start = total_errors();
        check_payload();
        end_test("payload and ram reads", err_start);
        err_start = total_errors();
        check_fcs();
        end_test("fcs", err_start);

        err_start = total_errors();             // start pulse late in the frame
        send_frame(LATE_PULSE);
        frames_before = frames_seen;
        repeat (QUIET_CYCLES)
        begin
            @(negedge i_sclk50);
            check_hex("o_tx_en", 32'(o_tx_en), 32'h0);
            check_hex("o_ram_rden", 32'(o_ram_rden), 32'h0);
        end
        check_true(frames_seen == frames_before, "start during a frame sent a second frame");
        end_test("start ignored mid frame", err_start);

        fill_ram();                             // new header and payload
        randomize_header();
        err_start = total_errors();
        send_frame(0);
        check_layout();
        check_payload();
        check_fcs();
        end_test("second frame with new data", err_start);

        $display("tests run %0d, failed %0d, errors %0d",
                 tests_run, tests_failed, total_errors());
        if (tests_failed == 0 && total_errors() == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

    // overall limit on run time
    initial
    begin
        #200000;
        $display("watchdog timeout, the test sequence did not finish");
        $display("Simulation FAILED");
        $finish;
    end

endmodule

/* rmii_mac_tx.f */
+incdir+include
source/mac_tx_pkg.sv
source/mac_tx_sequencer.sv
source/mac_tx_byte_mux.sv
source/mac_tx_fcs.sv
source/mac_tx_dibit_serializer.sv
source/rmii_mac_tx.sv
testbench/tb_rmii_mac_tx.sv

/* run_sim.sh */
#!/bin/sh
# build and run the rmii mac transmitter testbench with verilator
# exits non-zero when the build, the run or the pass check fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f rmii_mac_tx.f \
    --top-module tb_rmii_mac_tx \
    -o sim_tb_rmii_mac_tx
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/sim_tb_rmii_mac_tx)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Simulation PASSED"; then
    exit 0
fi
exit 1
